// ==== Bender.yml ====
package:
  name: sys_cfg

sources:
  - verilog/sys_cfg_pkg.sv
  - verilog/video_geom_pkg.sv
  - verilog/hps_cmd_decoder.sv
  - verilog/video_cfg_regs.sv
  - verilog/umuldiv.sv
  - verilog/ar_window_calc.sv
  - verilog/sys_cfg_top.sv
  - target: test
    files:
      - dv/sys_cfg_props.sv
      - dv/sys_cfg_tb.sv

// ==== dv/sys_cfg_props.sv ====
`timescale 1ns/100ps

module sys_cfg_props (
	input  logic                                 clk_sys,
	input  logic                                 resetd,
	input  logic                                 i_io_strobe,
	input  logic                                 i_reg_wr,
	input  logic                                 i_win_upd,
	input  logic [video_geom_pkg::COORD_W-1:0]   i_hmin,
	input  logic [video_geom_pkg::COORD_W-1:0]   i_hmax,
	input  logic [video_geom_pkg::COORD_W-1:0]   i_vmin,
	input  logic [video_geom_pkg::COORD_W-1:0]   i_vmax
);

	import video_geom_pkg::*;

	int fail_cnt = 0;

	// Register write one cycle behind a host strobe
	wr_follows_strobe: assert property (@(posedge clk_sys) disable iff (resetd)
		i_reg_wr |-> $past(i_io_strobe))
	else begin
		fail_cnt++;
		$error("register write strobe without a host strobe one cycle earlier");
	end

	upd_single_cycle: assert property (@(posedge clk_sys) disable iff (resetd)
		i_win_upd |=> !i_win_upd)
	else begin
		fail_cnt++;
		$error("window update strobe held for two cycles");
	end

	// Window only moves on a publish
	win_held: assert property (@(posedge clk_sys) disable iff (resetd)
		!i_win_upd |-> $stable({i_hmin, i_hmax, i_vmin, i_vmax}))
	else begin
		fail_cnt++;
		$error("window outputs changed without an update strobe");
	end

endmodule

bind sys_cfg_top sys_cfg_props u_props (
	.clk_sys     (clk_sys),
	.resetd      (resetd),
	.i_io_strobe (i_io_strobe),
	.i_reg_wr    (reg_wr),
	.i_win_upd   (o_win_upd),
	.i_hmin      (o_hmin),
	.i_hmax      (o_hmax),
	.i_vmin      (o_vmin),
	.i_vmax      (o_vmax)
);

// ==== dv/sys_cfg_tb.sv ====
`timescale 1ns/100ps

module sys_cfg_tb;

	import sys_cfg_pkg::*;
	import video_geom_pkg::*;

	localparam int UPD_TIMEOUT = 400;

	logic               clk_sys;
	logic               resetd;
	logic               io_sel;
	logic               io_strobe;
	io_word_t           io_din;
	logic [RATIO_W-1:0] arx, ary;
	logic [LED_W-1:0]   led_status;
	logic [LED_W-1:0]   led;
	logic [COORD_W-1:0] hmin, hmax, vmin, vmax;
	logic               win_upd;

	// Reference copy of the host-visible configuration
	logic [COORD_W-1:0] m_width, m_height, m_vset, m_hset;
	logic               m_freescale;
	logic [RATIO_W-1:0] m_arc1x, m_arc1y, m_arc2x, m_arc2y;
	logic [RATIO_W-1:0] m_arx, m_ary;
	logic [LED_W-1:0]   m_led_ov, m_led_st;

	int     errors;
	int     checks;
	integer seed;
	logic   timed_out;

	sys_cfg_top i_dut (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_io_sel     (io_sel),
		.i_io_strobe  (io_strobe),
		.i_io_din     (io_din),
		.i_arx        (arx),
		.i_ary        (ary),
		.i_led_status (led_status),
		.o_led        (led),
		.o_hmin       (hmin),
		.o_hmax       (hmax),
		.o_vmin       (vmin),
		.o_vmax       (vmax),
		.o_win_upd    (win_upd)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic logic [47:0] model_window();
		logic [COORD_W-1:0] eff_w, eff_h, rx, ry;
		logic [COORD_W-1:0] wcalc, hcalc, vis_w, vis_h;
		logic [COORD_W-1:0] h_lo, h_hi, v_lo, v_hi;
		logic               is_abs;
		eff_w = (m_hset != 0 && m_hset < m_width) ? m_hset : m_width;
		eff_h = (m_vset != 0 && m_vset < m_height) ? m_vset : m_height;
		rx = '0;
		ry = '0;
		is_abs = 1'b0;
		if (m_ary == 0) begin
			if (m_arx == 1) begin
				{rx, ry} = {m_arc1x[11:0], m_arc1y[11:0]};
				is_abs = m_arc1x[12] | m_arc1y[12];
			end else if (m_arx == 2) begin
				{rx, ry} = {m_arc2x[11:0], m_arc2y[11:0]};
				is_abs = m_arc2x[12] | m_arc2y[12];
			end
		end else begin
			{rx, ry} = {m_arx[11:0], m_ary[11:0]};
			is_abs = m_arx[12] | m_ary[12];
		end
		if (m_freescale || rx == 0 || ry == 0) begin
			wcalc = eff_w;
			hcalc = eff_h;
		end else if (is_abs) begin
			wcalc = rx;
			hcalc = ry;
		end else begin
			wcalc = 12'((24'(eff_h) * 24'(rx)) / 24'(ry));
			hcalc = 12'((24'(eff_w) * 24'(ry)) / 24'(rx));
		end
		vis_w = (wcalc < eff_w) ? wcalc : eff_w;
		vis_h = (hcalc < eff_h) ? hcalc : eff_h;
		h_lo = (m_width - vis_w) >> 1;
		h_hi = h_lo + vis_w - 12'd1;
		v_lo = (m_height - vis_h) >> 1;
		v_hi = v_lo + vis_h - 12'd1;
		return {h_lo, h_hi, v_lo, v_hi};
	endfunction

	// Per bit, an overridden LED shows the host state
	function automatic logic [LED_W-1:0] led_expect(input logic [LED_W-1:0] status);
		logic [LED_W-1:0] res;
		for (int b = 0; b < LED_W; b++) begin
			res[b] = m_led_ov[b] ? m_led_st[b] : status[b];
		end
		return res;
	endfunction

	////////////////////////////////////////
	// Host side
	////////////////////////////////////////

	task automatic host_word(input io_word_t w);
		@(posedge clk_sys);
		#2;
		io_strobe = 1'b1;
		io_din    = w;
		@(posedge clk_sys);
		#2;
		io_strobe = 1'b0;
	endtask

	task automatic open_frame(input logic [7:0] code);
		io_word_t w;
		w          = '0;
		w.cmd.code = code;
		@(posedge clk_sys);
		#2;
		io_sel = 1'b1;
		host_word(w);
	endtask

	task automatic coord_word(input logic flag, input logic [COORD_W-1:0] value);
		io_word_t w;
		w             = '0;
		w.coord.flag  = flag;
		w.coord.value = value;
		host_word(w);
	endtask

	// Leaves time for the registers and the calculator inputs to settle
	task automatic close_frame();
		@(posedge clk_sys);
		#2;
		io_sel = 1'b0;
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic set_mode(input logic [COORD_W-1:0] w, input logic [COORD_W-1:0] h);
		open_frame(CMD_VMODE);
		coord_word(1'b0, w);
		coord_word(1'b0, 12'd100);
		coord_word(1'b0, 12'd200);
		coord_word(1'b0, 12'd300);
		coord_word(1'b0, h);
		close_frame();
		m_width  = w;
		m_height = h;
	endtask

	task automatic set_limits(input logic fs, input logic [COORD_W-1:0] hs,
			input logic [COORD_W-1:0] vs);
		open_frame(CMD_VSET);
		coord_word(1'b0, vs);
		close_frame();
		open_frame(CMD_HSET);
		coord_word(fs, hs);
		close_frame();
		m_vset      = vs;
		m_hset      = hs;
		m_freescale = fs;
	endtask

	task automatic set_custom(input logic [RATIO_W-1:0] ax1, input logic [RATIO_W-1:0] ay1,
			input logic [RATIO_W-1:0] ax2, input logic [RATIO_W-1:0] ay2);
		open_frame(CMD_ARC);
		coord_word(ax1[12], ax1[11:0]);
		coord_word(ay1[12], ay1[11:0]);
		coord_word(ax2[12], ax2[11:0]);
		coord_word(ay2[12], ay2[11:0]);
		close_frame();
		{m_arc1x, m_arc1y, m_arc2x, m_arc2y} = {ax1, ay1, ax2, ay2};
	endtask

	task automatic set_ratio(input logic [RATIO_W-1:0] x, input logic [RATIO_W-1:0] y);
		@(posedge clk_sys);
		#2;
		arx   = x;
		ary   = y;
		m_arx = x;
		m_ary = y;
	endtask

	////////////////////////////////////////
	// Checking
	////////////////////////////////////////

	task automatic print_counts();
		$display("Checks: %0d, value errors: %0d, property errors: %0d",
			checks, errors, i_dut.u_props.fail_cnt);
	endtask

	task automatic check_value(input string sig, input logic [COORD_W-1:0] got,
			input logic [COORD_W-1:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERROR at %0t: %s = %0d, expected %0d", $time, sig, got, exp);
		end
	endtask

	task automatic wait_updates(input int n);
		int seen;
		int cyc;
		seen = 0;
		cyc  = 0;
		while (!timed_out && seen < n && cyc < UPD_TIMEOUT) begin
			@(posedge clk_sys);
			#1;
			if (win_upd) seen++;
			cyc++;
		end
		if (!timed_out && seen < n) begin
			timed_out = 1'b1;
			$display("Window update did not arrive within %0d cycles at %0t",
				UPD_TIMEOUT, $time);
		end
	endtask

	task automatic check_window();
		logic [47:0] exp;
		wait_updates(2);
		if (!timed_out) begin
			exp = model_window();
			check_value("o_hmin", hmin, exp[47:36]);
			check_value("o_hmax", hmax, exp[35:24]);
			check_value("o_vmin", vmin, exp[23:12]);
			check_value("o_vmax", vmax, exp[11:0]);
		end
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic test_reset_window();
		check_window();
		if (!timed_out) begin
			check_value("o_hmax", hmax, 12'd1919);
			check_value("o_vmax", vmax, 12'd1079);
		end
	endtask

	task automatic test_mode_pillarbox();
		set_mode(12'd1280, 12'd720);
		set_ratio(13'd4, 13'd3);
		check_window();
	endtask

	task automatic test_size_limits();
		set_limits(1'b0, 12'd1000, 12'd600);
		check_window();
		set_limits(1'b1, 12'd1000, 12'd600);
		check_window();
		set_limits(1'b0, 12'd0, 12'd0);
		check_window();
	endtask

	task automatic test_custom_ratios();
		int i;
		logic [RATIO_W-1:0] rx, ry;
		set_mode(12'd1920, 12'd1080);
		set_custom(13'd16, 13'd9, {1'b1, 12'd1440}, 13'd1080);
		set_ratio(13'd1, 13'd0);
		check_window();
		set_ratio(13'd2, 13'd0);
		check_window();
		set_ratio(13'd3, 13'd0);
		check_window();
		for (i = 0; i < 8; i++) begin
			rx = 13'(1 + ({$random(seed)} % 64));
			ry = 13'(1 + ({$random(seed)} % 64));
			set_ratio(rx, ry);
			check_window();
		end
	endtask

	task automatic test_led_override();
		io_word_t w;
		w = 16'h0FA5;
		open_frame(CMD_LED);
		host_word(w);
		close_frame();
		{m_led_ov, m_led_st} = w;
		#2;
		led_status = 8'h3C;
		repeat (2) @(posedge clk_sys);
		check_value("o_led", 12'(led), 12'(led_expect(led_status)));
		#2;
		led_status = 8'hC3;
		repeat (2) @(posedge clk_sys);
		check_value("o_led", 12'(led), 12'(led_expect(led_status)));
	endtask

	// Select drop between code and data, then a frame with no valid code
	task automatic test_frame_cancel();
		set_ratio(13'd0, 13'd0);
		open_frame(CMD_VSET);
		@(posedge clk_sys);
		#2;
		io_sel = 1'b0;
		@(posedge clk_sys);
		#2;
		io_sel = 1'b1;
		coord_word(1'b0, 12'h200);
		coord_word(1'b0, 12'h200);
		close_frame();
		check_window();
	endtask

	initial begin
		resetd      = 1'b1;
		io_sel      = 1'b0;
		io_strobe   = 1'b0;
		io_din      = '0;
		arx         = '0;
		ary         = '0;
		led_status  = '0;
		errors      = 0;
		checks      = 0;
		timed_out   = 1'b0;
		seed        = 32'h7a4e236f;
		m_width     = DEF_WIDTH;
		m_height    = DEF_HEIGHT;
		{m_vset, m_hset, m_freescale} = '0;
		{m_arc1x, m_arc1y, m_arc2x, m_arc2y} = '0;
		{m_arx, m_ary, m_led_ov, m_led_st} = '0;

		repeat (5) @(posedge clk_sys);
		#2;
		resetd = 1'b0;

		test_reset_window();
		test_mode_pillarbox();
		test_size_limits();
		test_custom_ratios();
		test_led_override();
		test_frame_cancel();

		print_counts();
		if (!timed_out && errors == 0 && i_dut.u_props.fail_cnt == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== list.f ====
verilog/sys_cfg_pkg.sv
verilog/video_geom_pkg.sv
verilog/hps_cmd_decoder.sv
verilog/video_cfg_regs.sv
verilog/umuldiv.sv
verilog/ar_window_calc.sv
verilog/sys_cfg_top.sv
dv/sys_cfg_props.sv
dv/sys_cfg_tb.sv

// ==== verilog/ar_window_calc.sv ====
`timescale 1ns/100ps

module ar_window_calc (
	input  logic                                 clk_sys,
	input  logic                                 resetd,

	input  logic [video_geom_pkg::COORD_W-1:0]   i_width,
	input  logic [video_geom_pkg::COORD_W-1:0]   i_height,
	input  logic [video_geom_pkg::COORD_W-1:0]   i_vset,
	input  logic [video_geom_pkg::COORD_W-1:0]   i_hset,
	input  logic                                 i_freescale,
	input  logic [video_geom_pkg::RATIO_W-1:0]   i_arc1x,
	input  logic [video_geom_pkg::RATIO_W-1:0]   i_arc1y,
	input  logic [video_geom_pkg::RATIO_W-1:0]   i_arc2x,
	input  logic [video_geom_pkg::RATIO_W-1:0]   i_arc2y,
	input  logic [video_geom_pkg::RATIO_W-1:0]   i_arx,
	input  logic [video_geom_pkg::RATIO_W-1:0]   i_ary,

	output logic [video_geom_pkg::COORD_W-1:0]   o_hmin,
	output logic [video_geom_pkg::COORD_W-1:0]   o_hmax,
	output logic [video_geom_pkg::COORD_W-1:0]   o_vmin,
	output logic [video_geom_pkg::COORD_W-1:0]   o_vmax,
	output logic                                 o_win_upd
);

	import video_geom_pkg::*;

	logic [COORD_W-1:0] eff_w, eff_h;
	logic [COORD_W-1:0] rx, ry;
	logic               ratio_abs;
	logic [COORD_W-1:0] wcalc, hcalc;
	logic [COORD_W-1:0] vis_w, vis_h;
	logic [2:0]         state;

	logic               md_start;
	logic               md_busy;
	logic [COORD_W-1:0] md_mul1, md_mul2, md_div;
	logic [COORD_W-1:0] md_res;

	umuldiv u_muldiv (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_start  (md_start),
		.i_mul1   (md_mul1),
		.i_mul2   (md_mul2),
		.i_div    (md_div),
		.o_busy   (md_busy),
		.o_result (md_res)
	);

	////////////////////////////////////////
	// Effective size and ratio select
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		eff_w <= (i_hset != '0 && i_hset < i_width) ? i_hset : i_width;
		eff_h <= (i_vset != '0 && i_vset < i_height) ? i_vset : i_height;

		if (i_ary == '0) begin
			// Core asks for a custom ratio by number
			if (i_arx == RATIO_W'(1)) begin
				rx        <= i_arc1x[COORD_W-1:0];
				ry        <= i_arc1y[COORD_W-1:0];
				ratio_abs <= i_arc1x[COORD_W] | i_arc1y[COORD_W];
			end else if (i_arx == RATIO_W'(2)) begin
				rx        <= i_arc2x[COORD_W-1:0];
				ry        <= i_arc2y[COORD_W-1:0];
				ratio_abs <= i_arc2x[COORD_W] | i_arc2y[COORD_W];
			end else begin
				rx        <= '0;
				ry        <= '0;
				ratio_abs <= 1'b0;
			end
		end else begin
			rx        <= i_arx[COORD_W-1:0];
			ry        <= i_ary[COORD_W-1:0];
			ratio_abs <= i_arx[COORD_W] | i_ary[COORD_W];
		end
	end

	////////////////////////////////////////
	// Window pass
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state     <= '0;
			md_start  <= 1'b0;
			o_win_upd <= 1'b0;
			o_hmin    <= '0;
			o_hmax    <= '0;
			o_vmin    <= '0;
			o_vmax    <= '0;
		end else begin
			md_start  <= 1'b0;
			o_win_upd <= 1'b0;
			state     <= state + 1'b1;

			case (state)
				0: begin
					if (i_freescale || rx == '0 || ry == '0) begin
						wcalc <= eff_w;
						hcalc <= eff_h;
						state <= 3'd5;
					end else if (ratio_abs) begin
						wcalc <= rx;
						hcalc <= ry;
						state <= 3'd5;
					end
				end
				// Width from height
				1: begin
					md_mul1  <= eff_h;
					md_mul2  <= rx;
					md_div   <= ry;
					md_start <= 1'b1;
				end
				2: begin
					wcalc <= md_res;
					if (md_start | md_busy) state <= 3'd2;
				end
				// Height from width
				3: begin
					md_mul1  <= eff_w;
					md_mul2  <= ry;
					md_div   <= rx;
					md_start <= 1'b1;
				end
				4: begin
					hcalc <= md_res;
					if (md_start | md_busy) state <= 3'd4;
				end
				5: begin
					vis_w <= (wcalc > eff_w) ? eff_w : wcalc;
					vis_h <= (hcalc > eff_h) ? eff_h : hcalc;
				end
				default: begin
					// Centre and publish
					o_hmin    <= (i_width - vis_w) >> 1;
					o_hmax    <= ((i_width - vis_w) >> 1) + vis_w - 1'b1;
					o_vmin    <= (i_height - vis_h) >> 1;
					o_vmax    <= ((i_height - vis_h) >> 1) + vis_h - 1'b1;
					o_win_upd <= 1'b1;
					state     <= '0;
				end
			endcase
		end
	end

endmodule

// ==== verilog/hps_cmd_decoder.sv ====
`timescale 1ns/100ps

module hps_cmd_decoder (
	input  logic                                 clk_sys,
	input  logic                                 resetd,

	input  logic                                 i_io_sel,
	input  logic                                 i_io_strobe,
	input  sys_cfg_pkg::io_word_t                i_io_din,

	output logic                                 o_reg_wr,
	output logic [7:0]                           o_reg_cmd,
	output logic [sys_cfg_pkg::WORD_CNT_W-1:0]   o_reg_idx,
	output sys_cfg_pkg::io_word_t                o_reg_data
);

	import sys_cfg_pkg::*;

	logic                  has_cmd;
	logic [WORD_CNT_W-1:0] word_cnt;
	logic                  data_stb;

	// Strobe after the code word
	assign data_stb = i_io_sel & i_io_strobe & has_cmd;

	////////////////////////////////////////
	// Frame tracking
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd   <= 1'b0;
			o_reg_cmd <= '0;
			word_cnt  <= '0;
			o_reg_wr  <= 1'b0;
		end else begin
			o_reg_wr <= 1'b0;

			if (!i_io_sel) begin
				// Frame closed, pending command dropped
				has_cmd <= 1'b0;
			end else if (i_io_strobe) begin
				if (!has_cmd) begin
					has_cmd   <= 1'b1;
					o_reg_cmd <= i_io_din.cmd.code;
					word_cnt  <= '0;
				end else begin
					o_reg_wr <= 1'b1;
					// Stays on the last index
					if (word_cnt != '1) begin
						word_cnt <= word_cnt + 1'b1;
					end
				end
			end
		end
	end

	////////////////////////////////////////
	// Write payload
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (data_stb) begin
			o_reg_idx  <= word_cnt;
			o_reg_data <= i_io_din;
		end
	end

endmodule

// ==== verilog/sys_cfg_pkg.sv ====
package sys_cfg_pkg;

	// Host word
	localparam int IO_W       = 16;
	localparam int WORD_CNT_W = 4;

	// Command codes
	localparam logic [7:0] CMD_VMODE = 8'h20;
	localparam logic [7:0] CMD_LED   = 8'h25;
	localparam logic [7:0] CMD_VSET  = 8'h27;
	localparam logic [7:0] CMD_HSET  = 8'h37;
	localparam logic [7:0] CMD_ARC   = 8'h3A;

	// First word of a frame
	typedef struct packed {
		logic [7:0] rsvd;
		logic [7:0] code;
	} cmd_view_t;

	// Data word carrying a 12-bit coordinate and a flag
	typedef struct packed {
		logic       flag;
		logic [2:0] rsvd;
		logic [11:0] value;
	} coord_view_t;

	typedef union packed {
		cmd_view_t   cmd;
		coord_view_t coord;
	} io_word_t;

endpackage

// ==== verilog/sys_cfg_top.sv ====
`timescale 1ns/100ps

module sys_cfg_top (
	input  logic                                 clk_sys,
	input  logic                                 resetd,

	input  logic                                 i_io_sel,
	input  logic                                 i_io_strobe,
	input  sys_cfg_pkg::io_word_t                i_io_din,

	input  logic [video_geom_pkg::RATIO_W-1:0]   i_arx,
	input  logic [video_geom_pkg::RATIO_W-1:0]   i_ary,
	input  logic [video_geom_pkg::LED_W-1:0]     i_led_status,

	output logic [video_geom_pkg::LED_W-1:0]     o_led,
	output logic [video_geom_pkg::COORD_W-1:0]   o_hmin,
	output logic [video_geom_pkg::COORD_W-1:0]   o_hmax,
	output logic [video_geom_pkg::COORD_W-1:0]   o_vmin,
	output logic [video_geom_pkg::COORD_W-1:0]   o_vmax,
	output logic                                 o_win_upd
);

	import sys_cfg_pkg::*;
	import video_geom_pkg::*;

	logic                  reg_wr;
	logic [7:0]            reg_cmd;
	logic [WORD_CNT_W-1:0] reg_idx;
	io_word_t              reg_data;

	logic [COORD_W-1:0]    width, height, vset, hset;
	logic                  freescale;
	logic [RATIO_W-1:0]    arc1x, arc1y, arc2x, arc2y;

	hps_cmd_decoder u_decoder (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_io_sel    (i_io_sel),
		.i_io_strobe (i_io_strobe),
		.i_io_din    (i_io_din),
		.o_reg_wr    (reg_wr),
		.o_reg_cmd   (reg_cmd),
		.o_reg_idx   (reg_idx),
		.o_reg_data  (reg_data)
	);

	video_cfg_regs u_regs (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_reg_wr     (reg_wr),
		.i_reg_cmd    (reg_cmd),
		.i_reg_idx    (reg_idx),
		.i_reg_data   (reg_data),
		.i_led_status (i_led_status),
		.o_width      (width),
		.o_height     (height),
		.o_vset       (vset),
		.o_hset       (hset),
		.o_freescale  (freescale),
		.o_arc1x      (arc1x),
		.o_arc1y      (arc1y),
		.o_arc2x      (arc2x),
		.o_arc2y      (arc2y),
		.o_led        (o_led)
	);

	ar_window_calc u_window (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_width     (width),
		.i_height    (height),
		.i_vset      (vset),
		.i_hset      (hset),
		.i_freescale (freescale),
		.i_arc1x     (arc1x),
		.i_arc1y     (arc1y),
		.i_arc2x     (arc2x),
		.i_arc2y     (arc2y),
		.i_arx       (i_arx),
		.i_ary       (i_ary),
		.o_hmin      (o_hmin),
		.o_hmax      (o_hmax),
		.o_vmin      (o_vmin),
		.o_vmax      (o_vmax),
		.o_win_upd   (o_win_upd)
	);

endmodule

// ==== verilog/umuldiv.sv ====
`timescale 1ns/100ps

module umuldiv (
	input  logic                                 clk_sys,
	input  logic                                 resetd,
	input  logic                                 i_start,
	input  logic [video_geom_pkg::COORD_W-1:0]   i_mul1,
	input  logic [video_geom_pkg::COORD_W-1:0]   i_mul2,
	input  logic [video_geom_pkg::COORD_W-1:0]   i_div,
	output logic                                 o_busy,
	output logic [video_geom_pkg::COORD_W-1:0]   o_result
);

	import video_geom_pkg::*;

	logic [PROD_W-1:0]    quot;
	logic [COORD_W-1:0]   rem;
	logic [COORD_W-1:0]   divisor;
	logic [DIV_CNT_W-1:0] step;
	logic [COORD_W:0]     trial;

	// Partial remainder with next dividend bit
	assign trial    = {rem, quot[PROD_W-1]};
	assign o_result = quot[COORD_W-1:0];

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_busy <= 1'b0;
			step   <= '0;
		end else if (i_start) begin
			o_busy <= 1'b1;
			step   <= '0;
		end else if (o_busy) begin
			if (step == DIV_CNT_W'(PROD_W - 1)) o_busy <= 1'b0;
			else step <= step + 1'b1;
		end
	end

	// Product shifts out while quotient bits shift in
	always_ff @(posedge clk_sys) begin
		if (i_start) begin
			quot    <= i_mul1 * i_mul2;
			rem     <= '0;
			divisor <= i_div;
		end else if (o_busy) begin
			if (trial >= {1'b0, divisor}) begin
				rem  <= COORD_W'(trial - {1'b0, divisor});
				quot <= {quot[PROD_W-2:0], 1'b1};
			end else begin
				rem  <= trial[COORD_W-1:0];
				quot <= {quot[PROD_W-2:0], 1'b0};
			end
		end
	end

endmodule

// ==== verilog/video_cfg_regs.sv ====
`timescale 1ns/100ps

module video_cfg_regs (
	input  logic                                 clk_sys,
	input  logic                                 resetd,

	input  logic                                 i_reg_wr,
	input  logic [7:0]                           i_reg_cmd,
	input  logic [sys_cfg_pkg::WORD_CNT_W-1:0]   i_reg_idx,
	input  sys_cfg_pkg::io_word_t                i_reg_data,
	input  logic [video_geom_pkg::LED_W-1:0]     i_led_status,

	output logic [video_geom_pkg::COORD_W-1:0]   o_width,
	output logic [video_geom_pkg::COORD_W-1:0]   o_height,
	output logic [video_geom_pkg::COORD_W-1:0]   o_vset,
	output logic [video_geom_pkg::COORD_W-1:0]   o_hset,
	output logic                                 o_freescale,
	output logic [video_geom_pkg::RATIO_W-1:0]   o_arc1x,
	output logic [video_geom_pkg::RATIO_W-1:0]   o_arc1y,
	output logic [video_geom_pkg::RATIO_W-1:0]   o_arc2x,
	output logic [video_geom_pkg::RATIO_W-1:0]   o_arc2y,
	output logic [video_geom_pkg::LED_W-1:0]     o_led
);

	import sys_cfg_pkg::*;
	import video_geom_pkg::*;

	logic [LED_W-1:0]   led_override;
	logic [LED_W-1:0]   led_state;
	logic [RATIO_W-1:0] arc_word;

	// Flag on top of the 12-bit value
	assign arc_word = {i_reg_data.coord.flag, i_reg_data.coord.value};

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_width      <= DEF_WIDTH;
			o_height     <= DEF_HEIGHT;
			o_vset       <= '0;
			o_hset       <= '0;
			o_freescale  <= 1'b0;
			o_arc1x      <= '0;
			o_arc1y      <= '0;
			o_arc2x      <= '0;
			o_arc2y      <= '0;
			led_override <= '0;
			led_state    <= '0;
		end else if (i_reg_wr) begin
			case (i_reg_cmd)
				CMD_VMODE: begin
					// Only active width and height kept
					if (i_reg_idx == 0) o_width  <= i_reg_data.coord.value;
					if (i_reg_idx == 4) o_height <= i_reg_data.coord.value;
				end
				CMD_LED: begin
					if (i_reg_idx == 0) begin
						led_override <= i_reg_data[IO_W-1:LED_W];
						led_state    <= i_reg_data[LED_W-1:0];
					end
				end
				CMD_VSET: begin
					if (i_reg_idx == 0) o_vset <= i_reg_data.coord.value;
				end
				CMD_HSET: begin
					if (i_reg_idx == 0) begin
						o_freescale <= i_reg_data.coord.flag;
						o_hset      <= i_reg_data.coord.value;
					end
				end
				CMD_ARC: begin
					case (i_reg_idx)
						0: o_arc1x <= arc_word;
						1: o_arc1y <= arc_word;
						2: o_arc2x <= arc_word;
						3: o_arc2y <= arc_word;
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

	// Overridden bits take the host state
	assign o_led = (led_override & led_state) | (~led_override & i_led_status);

endmodule

// ==== verilog/video_geom_pkg.sv ====
package video_geom_pkg;

	// Coordinates and sizes
	localparam int COORD_W = 12;

	// Ratio word, top bit flags an absolute size
	localparam int RATIO_W = COORD_W + 1;

	// Multiply-divide datapath
	localparam int PROD_W    = 2 * COORD_W;
	localparam int DIV_CNT_W = $clog2(PROD_W);

	// 1920x1080 after reset
	localparam logic [COORD_W-1:0] DEF_WIDTH  = 12'd1920;
	localparam logic [COORD_W-1:0] DEF_HEIGHT = 12'd1080;

	// Main board LEDs
	localparam int LED_W = 8;

endpackage
